// File: tests/ft245_testdata.txt
// header words: rx_count tx_count txe_busy_percent host_pause_cycles (all hex)
// then rx_count chip-to-host bytes, then tx_count host-to-chip bytes
18 14 1e 3c
// chip-to-host bytes, more than the rx FIFO depth
a5 5a 00 ff 01 02 04 08
10 20 40 80 3c c3 7e e7
11 22 33 44 55 66 77 88
// host-to-chip bytes
de ad be ef ca fe 12 34
56 78 9a bc f0 0f 69 96
aa 55 13 37

// File: all.f
rtl/ft245_pkg.sv
rtl/fifo_if.sv
rtl/byte_fifo.sv
rtl/ft245_bus_seq.sv
rtl/ft245_bridge.sv
tests/ft245_chip_model.sv
tests/ft245_checker.sv
tests/tb_ft245_bridge.sv

// File: Bender.yml
package:
  name: ft245_bridge

sources:
  - rtl/ft245_pkg.sv
  - rtl/fifo_if.sv
  - rtl/byte_fifo.sv
  - rtl/ft245_bus_seq.sv
  - rtl/ft245_bridge.sv
  - target: test
    files:
      - tests/ft245_chip_model.sv
      - tests/ft245_checker.sv
      - tests/tb_ft245_bridge.sv

// File: tests/tb_ft245_bridge.sv
// testbench for ft245_bridge; run from the project root so tests/ft245_testdata.txt is found
`timescale 1ns/1ps

module tb_ft245_bridge import ft245_pkg::*; ();

	localparam int FIFO_ADDR_W = 4;
	// four header words, then 24 rx and 20 tx bytes
	localparam int TD_WORDS    = 48;

	logic       ftdi_clk;
	logic       rst;
	wire  [7:0] ftdi_data;
	logic       oe_n;
	logic       rd_n;
	logic       wr_n;
	logic       rxf_n;
	logic       txe_n;
	logic       rx_pop;
	logic       rx_empty;
	byte_t      rx_data;
	logic       tx_push;
	byte_t      tx_data;
	logic       tx_full;

	byte_t td [0:TD_WORDS-1];
	int    rx_count;
	int    tx_count;
	int    busy_pct;
	int    pause_cycles;
	int    limit_cycles;

	ft245_bridge #(.FIFO_ADDR_W(FIFO_ADDR_W)) dut0 (
		.ftdi_clk  (ftdi_clk),
		.rst       (rst),
		.rxf_n     (rxf_n),
		.txe_n     (txe_n),
		.ftdi_data (ftdi_data),
		.oe_n      (oe_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.rx_pop    (rx_pop),
		.rx_empty  (rx_empty),
		.rx_data   (rx_data),
		.tx_push   (tx_push),
		.tx_data   (tx_data),
		.tx_full   (tx_full)
	);

	ft245_chip_model model0 (
		.ftdi_clk     (ftdi_clk),
		.rst          (rst),
		.ftdi_data    (ftdi_data),
		.oe_n         (oe_n),
		.rd_n         (rd_n),
		.wr_n         (wr_n),
		.rxf_n        (rxf_n),
		.txe_n        (txe_n),
		.txe_busy_pct (busy_pct)
	);

	always #10 ftdi_clk = ~ftdi_clk;

	task automatic stop_on_failure();
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s expected %h got %h", name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic check_rx_byte(input byte_t exp, input byte_t act);
		if (act !== exp) begin
			$display("ERR rx_data expected %h got %h", exp, act);
			stop_on_failure();
		end
	endtask

	task automatic check_tx_byte(input byte_t exp, input byte_t act);
		if (act !== exp) begin
			$display("ERR ftdi_data expected %h got %h", exp, act);
			stop_on_failure();
		end
	endtask

	// host pops with a pause first, then random gaps
	task automatic drain_rx();
		int n;
		int gap;
		n   = 0;
		gap = 0;
		repeat (pause_cycles) @(posedge ftdi_clk);
		while (n < rx_count) begin
			@(posedge ftdi_clk);
			#2;
			rx_pop = 1'b0;
			if (gap > 0) begin
				gap--;
			end else if (!rx_empty) begin
				check_rx_byte(td[4 + n], rx_data);
				rx_pop = 1'b1;
				n++;
				gap = $urandom % 3;
			end
		end
		@(posedge ftdi_clk);
		#2;
		rx_pop = 1'b0;
	endtask

	// push whenever tx has room
	task automatic fill_tx();
		int n;
		n = 0;
		while (n < tx_count) begin
			@(posedge ftdi_clk);
			#2;
			tx_push = !tx_full;
			if (!tx_full) begin
				tx_data = td[4 + rx_count + n];
				n++;
			end
		end
		@(posedge ftdi_clk);
		#2;
		tx_push = 1'b0;
	endtask

	// bytes the chip model saw at its write edges
	task automatic collect_tx();
		int n;
		n = 0;
		while (n < tx_count) begin
			@(negedge ftdi_clk);
			while (model0.txq.size() > 0 && n < tx_count) begin
				check_tx_byte(td[4 + rx_count + n], model0.txq.pop_front());
				n++;
			end
		end
	endtask

	always @(negedge ftdi_clk) begin
		if (dut0.u_seq.u_chk.fail_count != 0) begin
			$display("a bus protocol assertion failed");
			stop_on_failure();
		end
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge ftdi_clk);
		$display("timeout, bytes still missing after %0d cycles", limit_cycles);
		stop_on_failure();
	end

	initial begin
		int i;
		ftdi_clk     = 1'b0;
		rst          = 1'b1;
		rx_pop       = 1'b0;
		tx_push      = 1'b0;
		tx_data      = 8'h00;
		busy_pct     = 0;
		limit_cycles = 0;
		void'($urandom(23));
		$readmemh("tests/ft245_testdata.txt", td);
		rx_count     = td[0];
		tx_count     = td[1];
		busy_pct     = td[2];
		pause_cycles = td[3];
		for (i = 0; i < rx_count; i++) begin
			model0.load_rx_byte(td[4 + i]);
		end
		limit_cycles = 40 * (rx_count + tx_count) + 200;
		repeat (10) @(posedge ftdi_clk);
		#2;
		rst = 1'b0;
		// idle state straight after reset
		check_bit("oe_n", 1'b1, oe_n);
		check_bit("rd_n", 1'b1, rd_n);
		check_bit("wr_n", 1'b1, wr_n);
		check_bit("rx_empty", 1'b1, rx_empty);
		check_bit("tx_full", 1'b0, tx_full);
		fork
			drain_rx();
			fill_tx();
			collect_tx();
		join
		repeat (4) @(posedge ftdi_clk);
		#2;
		if (model0.txq.size() != 0 || !rx_empty) begin
			$display("extra bytes showed up beyond the expected lists");
			stop_on_failure();
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

// File: tests/ft245_checker.sv
// bus protocol assertions bound into ft245_bus_seq; needs concurrent assertion and bind support
`timescale 1ns/1ps

module ft245_checker import ft245_pkg::*; (
	input logic       ftdi_clk,
	input logic       rst,
	input bus_state_t state,
	input logic       oe_n,
	input logic       rd_n,
	input logic       wr_n,
	input logic       rx_push,
	input logic       rx_full,
	input logic       tx_pop,
	input logic       tx_empty
);

	// number of failed assertions so far
	int fail_count = 0;

	// rd_n strobes only with the chip on the bus
	a_rd_needs_oe: assert property (@(posedge ftdi_clk) disable iff (rst)
		!rd_n |-> (!oe_n && state == READ))
		else begin
			$error("rd_n low while oe_n high");
			fail_count++;
		end

	// no write while the chip drives the bus
	a_wr_needs_no_oe: assert property (@(posedge ftdi_clk) disable iff (rst)
		!wr_n |-> oe_n)
		else begin
			$error("wr_n low while oe_n low");
			fail_count++;
		end

	a_no_push_full: assert property (@(posedge ftdi_clk) disable iff (rst)
		rx_push |-> !rx_full)
		else begin
			$error("push into full rx FIFO");
			fail_count++;
		end

	a_no_pop_empty: assert property (@(posedge ftdi_clk) disable iff (rst)
		tx_pop |-> !tx_empty)
		else begin
			$error("pop from empty tx FIFO");
			fail_count++;
		end

endmodule

bind ft245_bus_seq ft245_checker u_chk (
	.ftdi_clk (ftdi_clk),
	.rst      (rst),
	.state    (state),
	.oe_n     (oe_n),
	.rd_n     (rd_n),
	.wr_n     (wr_n),
	.rx_push  (rx.push),
	.rx_full  (rx.full),
	.tx_pop   (tx.pop),
	.tx_empty (tx.empty)
);

// File: tests/ft245_chip_model.sv
// behavioral FT245 sync chip; takes every wr_n strobe even while txe_n is high, no pin timing
`timescale 1ns/1ps

module ft245_chip_model import ft245_pkg::*; (
	input  logic       ftdi_clk,
	input  logic       rst,
	inout  wire  [7:0] ftdi_data,
	input  logic       oe_n,
	input  logic       rd_n,
	input  logic       wr_n,
	output logic       rxf_n,
	output logic       txe_n,
	input  int         txe_busy_pct
);

	// bytes waiting for the bridge, and bytes written by it
	byte_t rxq [$];
	byte_t txq [$];

	byte_t head;

	// chip owns the bus while oe_n is low
	assign ftdi_data = oe_n ? 8'hzz : head;

	initial begin
		rxf_n = 1'b1;
		txe_n = 1'b1;
		head  = 8'h00;
	end

	task automatic load_rx_byte(input byte_t b);
		rxq.push_back(b);
	endtask

	always @(posedge ftdi_clk) begin
		logic  rd_hit;
		logic  wr_hit;
		byte_t seen;
		rd_hit = !rd_n && !rxf_n;
		wr_hit = !wr_n;
		seen   = ftdi_data;
		// outputs move a little after the edge
		#2;
		if (rst) begin
			txe_n = 1'b1;
		end else begin
			if (rd_hit) begin
				rxq.delete(0);
			end
			if (wr_hit) begin
				txq.push_back(seen);
			end
			// random throttle on the write advice
			txe_n = (($urandom % 100) < txe_busy_pct);
		end
		rxf_n = (rxq.size() == 0);
		head  = (rxq.size() != 0) ? rxq[0] : 8'h00;
	end

endmodule

// File: rtl/ft245_bridge.sv
// FT245 sync FIFO bridge top; host side runs on ftdi_clk, rx_data valid while rx_empty low
`timescale 1ns/1ps

module ft245_bridge import ft245_pkg::*; #(
	parameter int FIFO_ADDR_W = FIFO_ADDR_W_DEFAULT
) (
	input  logic       ftdi_clk,
	input  logic       rst,

	// chip side
	input  logic       rxf_n,
	input  logic       txe_n,
	inout  wire  [7:0] ftdi_data,
	output logic       oe_n,
	output logic       rd_n,
	output logic       wr_n,

	// host receive side, pop when not empty
	input  logic       rx_pop,
	output logic       rx_empty,
	output byte_t      rx_data,

	// host transmit side, push when not full
	input  logic       tx_push,
	input  byte_t      tx_data,
	output logic       tx_full
);

	// chip to host
	fifo_if #(.FIFO_ADDR_W(FIFO_ADDR_W)) rx_if (
		.ftdi_clk (ftdi_clk),
		.rst      (rst)
	);

	// host to chip
	fifo_if #(.FIFO_ADDR_W(FIFO_ADDR_W)) tx_if (
		.ftdi_clk (ftdi_clk),
		.rst      (rst)
	);

	// registered byte from the sequencer
	byte_t bus_out;

	// pad drives only while the chip is told to stay off the bus
	assign ftdi_data = oe_n ? bus_out : 8'hzz;

	// host side of rx, the sequencer owns push and wdata
	assign rx_if.pop = rx_pop;
	assign rx_empty  = rx_if.empty;
	assign rx_data   = rx_if.rdata;

	// host side of tx, the sequencer owns pop
	assign tx_if.push  = tx_push;
	assign tx_if.wdata = tx_data;
	assign tx_full     = tx_if.full;

	byte_fifo #(
		.FIFO_ADDR_W (FIFO_ADDR_W)
	) u_rx_fifo (
		.f (rx_if.store)
	);

	byte_fifo #(
		.FIFO_ADDR_W (FIFO_ADDR_W)
	) u_tx_fifo (
		.f (tx_if.store)
	);

	ft245_bus_seq u_seq (
		.ftdi_clk (ftdi_clk),
		.rst      (rst),
		.rxf_n    (rxf_n),
		.txe_n    (txe_n),
		.bus_in   (ftdi_data),
		.bus_out  (bus_out),
		.oe_n     (oe_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.rx       (rx_if.user),
		.tx       (tx_if.user)
	);

endmodule

// File: rtl/ft245_bus_seq.sv
// FT245 sync bus sequencer; reads win over writes in IDLE, rx needs one free slot past almost_full
`timescale 1ns/1ps

module ft245_bus_seq import ft245_pkg::*; (
	input  logic  ftdi_clk,
	input  logic  rst,

	// chip status, active low
	input  logic  rxf_n,
	input  logic  txe_n,

	// chip data bus, split at the pad
	input  byte_t bus_in,
	output byte_t bus_out,

	// chip strobes, active low
	output logic  oe_n,
	output logic  rd_n,
	output logic  wr_n,

	// receive FIFO, filled from the chip
	fifo_if.user  rx,

	// transmit FIFO, drained to the chip
	fifo_if.user  tx
);

	bus_state_t state;

	// start conditions seen in IDLE
	logic read_req;
	logic write_req;

	// a byte moves towards the chip on this edge
	logic write_go;

	// chip has data and there is room for a burst
	assign read_req  = !rxf_n && !rx.almost_full;

	// only when nothing waits to be read
	assign write_req = rxf_n && !txe_n && !tx.empty;

	// in WRITE, one byte per cycle while the chip
	// has room and there is something to send
	assign write_go  = (state == WRITE) && !txe_n && !tx.empty;

	// rd_n is low exactly while in READ, so every
	// edge there with rxf_n low hands over a byte
	assign rx.push  = (state == READ) && !rxf_n;
	assign rx.wdata = bus_in;

	// head byte is taken into bus_out on the same edge
	assign tx.pop = write_go;

	always_ff @(posedge ftdi_clk) begin
		if (rst) begin
			state <= IDLE;
			oe_n  <= 1'b1;
			rd_n  <= 1'b1;
			wr_n  <= 1'b1;
		end else begin
			case (state)
				IDLE: begin
					// chip starts driving after oe_n falls
					if (read_req) begin
						oe_n  <= 1'b0;
						state <= READ_OE;
					end else if (write_req) begin
						state <= WRITE;
					end
				end

				READ_OE: begin
					// bus has turned around, start strobing
					// unless the chip ran dry meanwhile
					if (rxf_n) begin
						oe_n  <= 1'b1;
						state <= IDLE;
					end else begin
						rd_n  <= 1'b0;
						state <= READ;
					end
				end

				READ: begin
					// the byte on this edge is still pushed,
					// almost_full leaves room for it
					if (rxf_n || rx.almost_full) begin
						rd_n  <= 1'b1;
						oe_n  <= 1'b1;
						state <= IDLE;
					end
				end

				WRITE: begin
					if (write_go) begin
						wr_n <= 1'b0;
					end else begin
						// chip busy or nothing left to send
						wr_n  <= 1'b1;
						state <= IDLE;
					end
				end

				default: begin
					oe_n  <= 1'b1;
					rd_n  <= 1'b1;
					wr_n  <= 1'b1;
					state <= IDLE;
				end
			endcase
		end
	end

	// output byte register
	// only loaded together with a pop, no reset
	always_ff @(posedge ftdi_clk) begin
		if (write_go) begin
			bus_out <= tx.rdata;
		end
	end

endmodule

// File: rtl/byte_fifo.sv
// synchronous fall-through byte FIFO; push when full and pop when empty are dropped silently
`timescale 1ns/1ps

module byte_fifo import ft245_pkg::*; #(
	parameter int FIFO_ADDR_W = FIFO_ADDR_W_DEFAULT
) (
	fifo_if.store f
);

	localparam int DEPTH = 2 ** FIFO_ADDR_W;

	// flag thresholds at pointer width
	localparam logic [FIFO_ADDR_W:0] LVL_FULL   = (FIFO_ADDR_W + 1)'(DEPTH);
	localparam logic [FIFO_ADDR_W:0] LVL_ALMOST = (FIFO_ADDR_W + 1)'(DEPTH - 1);
	localparam logic [FIFO_ADDR_W:0] LVL_EMPTY  = '0;

	// storage
	byte_t mem [DEPTH];

	// pointers carry an extra wrap bit
	logic [FIFO_ADDR_W:0] wr_ptr;
	logic [FIFO_ADDR_W:0] rd_ptr;

	// qualified requests
	logic do_push;
	logic do_pop;

	assign do_push = f.push && !f.full;
	assign do_pop  = f.pop && !f.empty;

	// level from the pointer difference, wraps cleanly
	assign f.level = wr_ptr - rd_ptr;

	// flags follow the registered pointers,
	// so they move one edge after the push or pop
	assign f.empty       = (f.level == LVL_EMPTY);
	assign f.full        = (f.level == LVL_FULL);
	// one slot of slack for the byte the chip hands over
	// on the same edge that the sequencer sees this flag
	assign f.almost_full = (f.level >= LVL_ALMOST);

	always_ff @(posedge f.ftdi_clk) begin
		if (f.rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// array write, contents need no reset
	always_ff @(posedge f.ftdi_clk) begin
		if (do_push) begin
			mem[wr_ptr[FIFO_ADDR_W-1:0]] <= f.wdata;
		end
	end

	// fall-through read
	// head byte is visible without a pop
	assign f.rdata = mem[rd_ptr[FIFO_ADDR_W-1:0]];

endmodule

// File: rtl/fifo_if.sv
// one FIFO's push, pop, flags and data; the FIFO and both of its users must share ftdi_clk
`timescale 1ns/1ps

interface fifo_if import ft245_pkg::*; #(
	parameter int FIFO_ADDR_W = FIFO_ADDR_W_DEFAULT
) (
	input logic ftdi_clk,
	input logic rst
);

	// write side
	logic                 push;
	byte_t                wdata;

	// read side, rdata is valid whenever empty is low
	logic                 pop;
	byte_t                rdata;

	// status
	logic                 full;
	logic                 almost_full;
	logic                 empty;

	// fill level, one bit wider than the address so full fits
	logic [FIFO_ADDR_W:0] level;

	// the storage side
	modport store (
		input  ftdi_clk,
		input  rst,
		input  push,
		input  wdata,
		input  pop,
		output rdata,
		output full,
		output almost_full,
		output empty,
		output level
	);

	// anything that pushes or pops
	modport user (
		output push,
		output wdata,
		output pop,
		input  rdata,
		input  full,
		input  almost_full,
		input  empty
	);

endinterface

// File: rtl/ft245_pkg.sv
// shared types for the FT245 bridge; one clock domain only, FIFO depth must be a power of two
package ft245_pkg;

	// one byte on the chip bus or in either FIFO
	typedef logic [7:0] byte_t;

	// bus sequencer states
	// READ_OE is the turnaround cycle in which the chip takes the bus
	// before rd_n is allowed to fall
	typedef enum logic [1:0] {
		IDLE    = 2'd0,
		READ_OE = 2'd1,
		READ    = 2'd2,
		WRITE   = 2'd3
	} bus_state_t;

	// log2 of the FIFO depth
	// 4 gives 16 entries, which is enough to cover
	// one read burst after almost_full is seen
	// any value of 2 or more works
	parameter int FIFO_ADDR_W_DEFAULT = 4;

endpackage
